// ==== rv_core.f ====
+incdir+hw
hw/rv_pkg.sv
hw/rv_decode.sv
hw/rv_execute.sv
hw/rv_writeback.sv
hw/rv_regfile.sv
hw/rv_core.sv
testbench/tb_clock_gen.sv
testbench/rv_core_sva.sv
testbench/rv_core_tb.sv

// ==== Makefile ====
SIM        = verilator
TOP        = rv_core_tb
RTL_TOP    = rv_core
FILELIST   = rv_core.f
BUILD_DIR  = obj_dir
FLAGS      = --binary --timing --assert -Wno-fatal
LINT_FLAGS = --lint-only -Wall +incdir+hw
SIM_ARGS   = +verilator+error+limit+100
LOG        = sim.log
PASS_TEXT  = STATUS: PASS
RTL_SRCS   = hw/rv_pkg.sv hw/rv_decode.sv hw/rv_execute.sv hw/rv_writeback.sv \
             hw/rv_regfile.sv hw/rv_core.sv

.PHONY: all build run lint clean

all: run

build:
	$(SIM) $(FLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(BUILD_DIR)

run: build
	./$(BUILD_DIR)/V$(TOP) $(SIM_ARGS) | tee $(LOG)
	@grep -q "$(PASS_TEXT)" $(LOG) || (echo "simulation failed, see $(LOG)"; exit 1)

lint:
	$(SIM) $(LINT_FLAGS) --top-module $(RTL_TOP) $(RTL_SRCS)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// ==== testbench/rv_core_tb.sv ====
`timescale 1ns/1ps
`include "rv_core_cfg.svh"

module rv_core_tb;

    localparam int N_INSTR     = 56;  // instructions issued over all tests
    localparam int CLK_NS      = 100;
    localparam int RESET_CYC   = 16;
    localparam int WATCHDOG_NS = (N_INSTR * 8 + RESET_CYC) * CLK_NS * 2;

    localparam logic [6:0] OPC_OP    = 7'b0110011;
    localparam logic [6:0] OPC_IMM   = 7'b0010011;
    localparam logic [6:0] OPC_32    = 7'b0111011;
    localparam logic [6:0] OPC_IMM32 = 7'b0011011;
    localparam logic [6:0] OPC_LUI   = 7'b0110111;

    logic                       clk;
    logic                       rst_n;
    logic                       req;
    logic [31:0]                instr;
    logic [`REG_ADDR_WIDTH-1:0] dbg_raddr;
    logic                       ack;
    logic [`XLEN-1:0]           dbg_rdata;

    logic [`XLEN-1:0] shadow [`REG_DATA_DEPTH];  // reference register state
    logic [31:0]      rng;
    int               checks;
    int               fails;
    int               test_fails;

    tb_clock_gen #(.PERIOD_NS(CLK_NS)) clk_gen0 (.clk(clk));

    rv_core dut0 (
        .clk       (clk),
        .rst_n     (rst_n),
        .req       (req),
        .instr     (instr),
        .dbg_raddr (dbg_raddr),
        .ack       (ack),
        .dbg_rdata (dbg_rdata)
    );

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    function automatic logic [31:0] rand_word();
        rng = xorshift32(rng);
        return rng;
    endfunction

    function automatic logic [4:0] nonzero_reg(input logic [31:0] w);
        return 5'(w % 31 + 1);
    endfunction

    function automatic logic [63:0] sext32(input logic [31:0] v);
        return {{32{v[31]}}, v};
    endfunction

    function automatic logic [31:0] enc_r(input logic [6:0] f7, input logic [4:0] rs2,
                                          input logic [4:0] rs1, input logic [2:0] f3,
                                          input logic [4:0] rd, input logic [6:0] opc);
        return {f7, rs2, rs1, f3, rd, opc};
    endfunction

    function automatic logic [31:0] enc_i(input logic [11:0] imm, input logic [4:0] rs1,
                                          input logic [4:0] rd, input logic [6:0] opc);
        return {imm, rs1, 3'b000, rd, opc};  // funct3 zero: addi, addiw
    endfunction

    function automatic logic [31:0] enc_u(input logic [19:0] imm, input logic [4:0] rd);
        return {imm, rd, OPC_LUI};
    endfunction

    function automatic logic [31:0] r_op(input int k, input logic [4:0] rs2,
                                         input logic [4:0] rs1, input logic [4:0] rd);
        case (k)
            0:       return enc_r(7'h00, rs2, rs1, 3'b000, rd, OPC_OP);  // add
            1:       return enc_r(7'h20, rs2, rs1, 3'b000, rd, OPC_OP);  // sub
            2:       return enc_r(7'h00, rs2, rs1, 3'b111, rd, OPC_OP);  // and
            3:       return enc_r(7'h00, rs2, rs1, 3'b110, rd, OPC_OP);  // or
            4:       return enc_r(7'h00, rs2, rs1, 3'b100, rd, OPC_OP);  // xor
            5:       return enc_r(7'h00, rs2, rs1, 3'b001, rd, OPC_OP);  // sll
            default: return enc_r(7'h00, rs2, rs1, 3'b101, rd, OPC_OP);  // srl
        endcase
    endfunction

    function automatic string r_name(input int k);
        case (k)
            0:       return "r_type add";
            1:       return "r_type sub";
            2:       return "r_type and";
            3:       return "r_type or";
            4:       return "r_type xor";
            5:       return "r_type sll";
            default: return "r_type srl";
        endcase
    endfunction

    // ISA rules for the supported subset, applied after each retirement
    task automatic apply_model(input logic [31:0] ins);
        logic [63:0] a;
        logic [63:0] b;
        logic [63:0] imm;
        logic [63:0] res;
        logic        wen;
        a   = shadow[ins[19:15]];
        b   = shadow[ins[24:20]];
        imm = {{52{ins[31]}}, ins[31:20]};
        wen = 1'b1;
        res = '0;
        case (ins[6:0])
            OPC_OP: begin
                case (ins[14:12])
                    3'b000:  res = ins[30] ? a - b : a + b;
                    3'b001:  res = a << b[5:0];
                    3'b100:  res = a ^ b;
                    3'b101:  res = a >> b[5:0];
                    3'b110:  res = a | b;
                    3'b111:  res = a & b;
                    default: wen = 1'b0;
                endcase
            end
            OPC_IMM:   res = a + imm;
            OPC_32:    res = ins[30] ? sext32(a[31:0] - b[31:0]) : sext32(a[31:0] + b[31:0]);
            OPC_IMM32: res = sext32(a[31:0] + imm[31:0]);
            OPC_LUI:   res = sext32({ins[31:12], 12'h000});
            default:   wen = 1'b0;  // unknown opcode retires silently
        endcase
        if (wen && ins[11:7] != 5'd0) begin
            shadow[ins[11:7]] = res;
        end
    endtask

    task automatic check_eq(input string test, input logic [63:0] exp, input logic [63:0] act);
        checks++;
        assert (act === exp) else begin
            $display("mismatch %s: expected %h actual %h", test, exp, act);
            fails++;
            test_fails++;
        end
    endtask

    task automatic check_true(input logic ok, input string msg);
        checks++;
        assert (ok) else begin
            $display("%s", msg);
            fails++;
            test_fails++;
        end
    endtask

    // called on a falling edge, returns on the next one
    task automatic read_reg(input logic [4:0] addr, output logic [63:0] val);
        dbg_raddr = addr;
        @(negedge clk);
        val = dbg_rdata;
    endtask

    task automatic check_reg(input string test, input logic [4:0] addr);
        logic [63:0] val;
        read_reg(addr, val);
        check_eq($sformatf("%s x%0d", test, addr), shadow[addr], val);
    endtask

    // one four-phase transfer, then the destination and one random register
    task automatic execute(input string test, input logic [31:0] ins, input int hold);
        int edges;
        edges = 0;
        instr = ins;
        req   = 1'b1;
        do begin
            @(negedge clk);
            edges++;
        end while (!ack && edges < 16);
        repeat (hold) @(negedge clk);  // keep req up after ack
        req = 1'b0;
        @(negedge clk);
        check_true(ack === 1'b0, $sformatf("%s: ack still high after req was released", test));
        apply_model(ins);
        check_eq({test, " ack latency"}, 64'd4, 64'(edges - 1));  // first edge samples req
        check_reg(test, ins[11:7]);
        check_reg(test, 5'(rand_word()));
    endtask

    task automatic end_test(input string test);
        $display("test %-9s finished with %0d errors", test, test_fails);
        test_fails = 0;
    endtask

    initial begin
        #(WATCHDOG_NS);
        $display("watchdog expired after %0d ns, the run did not finish", WATCHDOG_NS);
        $display("STATUS: FAIL");
        $finish;
    end

    initial begin
        logic [63:0] val;
        logic [31:0] word;
        logic [11:0] imm;
        rng        = 32'd79;
        req        = 1'b0;
        instr      = '0;
        dbg_raddr  = '0;
        rst_n      = 1'b0;
        checks     = 0;
        fails      = 0;
        test_fails = 0;
        for (int i = 0; i < `REG_DATA_DEPTH; i++) begin
            shadow[i] = '0;
        end
        repeat (RESET_CYC) @(negedge clk);
        rst_n = 1'b1;

        check_true(ack === 1'b0, "ack is high after reset");
        for (int i = 0; i < `REG_DATA_DEPTH; i++) begin
            read_reg(5'(i), val);
            check_eq($sformatf("reset x%0d", i), 64'd0, val);
        end
        end_test("reset");

        for (int r = 1; r <= 8; r++) begin  // x1..x8 become r-type sources
            word = rand_word();
            execute("load lui", enc_u(word[19:0], 5'(r)), 0);
            word = rand_word();
            execute("load addi", enc_i(word[11:0], 5'(r), 5'(r), OPC_IMM), 0);
        end
        end_test("load");

        for (int k = 0; k < 14; k++) begin
            word = rand_word();
            execute(r_name(k % 7), r_op(k % 7, 5'(word[2:0] + 1), 5'(word[5:3] + 1),
                    nonzero_reg(word >> 8)), 0);
        end
        end_test("r_type");

        for (int k = 0; k < 4; k++) begin
            word    = rand_word();
            imm     = word[11:0];
            imm[11] = (k < 2);  // two negative, two positive
            execute("imm addi", enc_i(imm, word[16:12], nonzero_reg(word >> 17), OPC_IMM), 0);
        end
        for (int k = 0; k < 3; k++) begin
            word = rand_word();
            execute("imm lui", enc_u(word[31:12], nonzero_reg(word)), 0);
        end
        end_test("imm");

        execute("word lui", enc_u(20'h40000, 5'd20), 0);  // 0x40000000
        execute("word lui", enc_u(20'h80000, 5'd24), 0);  // upper half all ones
        execute("word addw", enc_r(7'h00, 5'd20, 5'd20, 3'b000, 5'd21, OPC_32), 0);
        execute("word subw", enc_r(7'h20, 5'd20, 5'd0, 3'b000, 5'd22, OPC_32), 0);
        execute("word addiw", enc_i(12'h001, 5'd20, 5'd23, OPC_IMM32), 0);
        execute("word addiw", enc_i(12'hfff, 5'd24, 5'd25, OPC_IMM32), 0);  // 0x7fffffff
        execute("word addw", enc_r(7'h00, 5'd24, 5'd24, 3'b000, 5'd26, OPC_32), 0);
        execute("word subw", enc_r(7'h20, 5'd24, 5'd20, 3'b000, 5'd27, OPC_32), 0);
        for (int k = 0; k < 6; k++) begin
            word = rand_word();
            if (k % 3 == 2) begin
                execute("word addiw", enc_i(word[31:20], word[4:0], nonzero_reg(word >> 5),
                        OPC_IMM32), 0);
            end else begin
                execute("word addw/subw", enc_r({1'b0, word[10], 5'd0}, word[4:0],
                        word[9:5], 3'b000, nonzero_reg(word >> 11), OPC_32), 0);
            end
        end
        for (int r = 21; r <= 27; r++) begin
            read_reg(5'(r), val);
            check_eq($sformatf("word x%0d upper half", r), 64'({32{shadow[r][31]}}),
                     64'(val[63:32]));
        end
        end_test("word");

        word = rand_word();
        execute("x0 addi", enc_i(12'h005, 5'd1, 5'd0, OPC_IMM), 0);
        execute("x0 add", enc_r(7'h00, 5'd2, 5'd1, 3'b000, 5'd0, OPC_OP), 0);
        execute("x0 lui", enc_u(20'hfffff, 5'd0), 0);
        execute("unknown load", {word[31:7], 7'b0000011}, 3);
        execute("unknown jal", {word[31:7], 7'b1101111}, 0);
        for (int i = 0; i < `REG_DATA_DEPTH; i++) begin
            check_reg("no_write", 5'(i));
        end
        end_test("no_write");

        check_true(dut0.sva0.sva_errors == 0, "handshake assertions reported failures");
        $display("checks passed %0d failed %0d", checks - fails, fails);
        if (fails == 0) begin
            $display("STATUS: PASS");
        end else begin
            $display("STATUS: FAIL");
        end
        $finish;
    end

endmodule

// ==== testbench/rv_core_sva.sv ====
`timescale 1ns/1ps

module rv_core_sva (
    input logic clk,
    input logic rst_n,
    input logic req,
    input logic ack,
    input logic accept,
    input logic dec_valid,
    input logic ex_valid,
    input logic wb_done,
    input logic wr_en
);

    int sva_errors = 0;  // failure count, read by the testbench

    // ack is set by the fourth edge after the sampling edge, so it shows at the fifth sample
    property ack_latency;
        @(posedge clk) disable iff (!rst_n) $rose(req) |-> ##5 $rose(ack);
    endproperty

    property ack_needs_req;
        @(posedge clk) disable iff (!rst_n) $rose(ack) |-> $past(req);
    endproperty

    property ack_falls_after_release;
        @(posedge clk) disable iff (!rst_n) (ack && !req) |=> !ack;
    endproperty

    property ack_holds_with_req;
        @(posedge clk) disable iff (!rst_n) (ack && req) |=> ack;
    endproperty

    property quiet_after_reset;
        @(posedge clk) !rst_n |=> !(ack || accept || dec_valid || ex_valid || wb_done || wr_en);
    endproperty

    a_ack_latency: assert property (ack_latency) else begin
        $error("ack did not rise four cycles after req was sampled high");
        sva_errors++;
    end

    a_ack_needs_req: assert property (ack_needs_req) else begin
        $error("ack rose while req was low");
        sva_errors++;
    end

    a_ack_falls: assert property (ack_falls_after_release) else begin
        $error("ack did not fall one cycle after req was released");
        sva_errors++;
    end

    a_ack_holds: assert property (ack_holds_with_req) else begin
        $error("ack dropped while req was still high");
        sva_errors++;
    end

    a_reset: assert property (quiet_after_reset) else begin
        $error("handshake or pipeline strobe high after reset");
        sva_errors++;
    end

endmodule

bind rv_core rv_core_sva sva0 (
    .clk       (clk),
    .rst_n     (rst_n),
    .req       (req),
    .ack       (ack),
    .accept    (accept),
    .dec_valid (dec_valid),
    .ex_valid  (ex_valid),
    .wb_done   (wb_done),
    .wr_en     (wr_en)
);

// ==== testbench/tb_clock_gen.sv ====
`timescale 1ns/1ps

module tb_clock_gen #(
    parameter int PERIOD_NS = 100
) (
    output logic clk
);

    initial begin
        clk = 1'b0;
        forever #(PERIOD_NS / 2) clk = ~clk;  // 50/50 duty
    end

endmodule

// ==== hw/rv_core.sv ====
`timescale 1ns/1ps
`include "rv_core_cfg.svh"

module rv_core (
    input  logic                       clk,
    input  logic                       rst_n,
    input  logic                       req,
    input  logic [31:0]                instr,
    input  logic [`REG_ADDR_WIDTH-1:0] dbg_raddr,
    output logic                       ack,
    output logic [`XLEN-1:0]           dbg_rdata
);

    logic                       st_idle;
    logic                       st_busy;
    logic                       st_ack;
    logic                       accept;
    logic [`REG_ADDR_WIDTH-1:0] rs1_addr;
    logic [`REG_ADDR_WIDTH-1:0] rs2_addr;
    logic [`XLEN-1:0]           rs1_data;
    logic [`XLEN-1:0]           rs2_data;
    logic                       dec_valid;
    logic [`XLEN-1:0]           op_a;
    logic [`XLEN-1:0]           op_b;
    rv_pkg::alu_op_e            alu_op;
    logic                       word_op;
    logic [`REG_ADDR_WIDTH-1:0] rd;
    logic                       rd_wen;
    logic                       ex_valid;
    logic [`XLEN-1:0]           ex_result;
    logic [`REG_ADDR_WIDTH-1:0] ex_rd;
    logic                       ex_wen;
    rv_pkg::ext_mode_e          ext_mode;
    logic                       wr_en;
    logic [`REG_ADDR_WIDTH-1:0] wr_addr;
    logic [`XLEN-1:0]           wr_data;
    logic                       wb_done;

    // four-phase sequencing, one flag per state
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            st_idle <= 1'b1;
            st_busy <= 1'b0;
            st_ack  <= 1'b0;
            accept  <= 1'b0;
        end else begin
            accept <= st_idle && req;  // single pulse, state leaves idle
            if (st_idle && req) begin
                st_idle <= 1'b0;
                st_busy <= 1'b1;
            end
            if (st_busy && wb_done) begin
                st_busy <= 1'b0;
                st_ack  <= 1'b1;
            end
            if (st_ack && !req) begin  // env released req
                st_ack  <= 1'b0;
                st_idle <= 1'b1;
            end
        end
    end

    assign ack = st_ack;

    rv_decode u_decode (
        .clk       (clk),
        .rst_n     (rst_n),
        .accept    (accept),
        .instr     (instr),
        .rs1_data  (rs1_data),
        .rs2_data  (rs2_data),
        .rs1_addr  (rs1_addr),
        .rs2_addr  (rs2_addr),
        .dec_valid (dec_valid),
        .op_a      (op_a),
        .op_b      (op_b),
        .alu_op    (alu_op),
        .word_op   (word_op),
        .rd        (rd),
        .rd_wen    (rd_wen)
    );

    rv_execute u_execute (
        .clk       (clk),
        .rst_n     (rst_n),
        .dec_valid (dec_valid),
        .op_a      (op_a),
        .op_b      (op_b),
        .alu_op    (alu_op),
        .word_op   (word_op),
        .rd        (rd),
        .rd_wen    (rd_wen),
        .ex_valid  (ex_valid),
        .ex_result (ex_result),
        .ex_rd     (ex_rd),
        .ex_wen    (ex_wen),
        .ext_mode  (ext_mode)
    );

    rv_writeback u_writeback (
        .clk       (clk),
        .rst_n     (rst_n),
        .ex_valid  (ex_valid),
        .ex_result (ex_result),
        .ex_rd     (ex_rd),
        .ex_wen    (ex_wen),
        .ext_mode  (ext_mode),
        .wr_en     (wr_en),
        .wr_addr   (wr_addr),
        .wr_data   (wr_data),
        .wb_done   (wb_done)
    );

    rv_regfile u_regfile (
        .clk       (clk),
        .rst_n     (rst_n),
        .rs1_addr  (rs1_addr),
        .rs2_addr  (rs2_addr),
        .wr_en     (wr_en),
        .wr_addr   (wr_addr),
        .wr_data   (wr_data),
        .dbg_raddr (dbg_raddr),
        .rs1_data  (rs1_data),
        .rs2_data  (rs2_data),
        .dbg_rdata (dbg_rdata)
    );

endmodule

// ==== hw/rv_regfile.sv ====
`timescale 1ns/1ps
`include "rv_core_cfg.svh"

module rv_regfile (
    input  logic                       clk,
    input  logic                       rst_n,
    input  logic [`REG_ADDR_WIDTH-1:0] rs1_addr,
    input  logic [`REG_ADDR_WIDTH-1:0] rs2_addr,
    input  logic                       wr_en,
    input  logic [`REG_ADDR_WIDTH-1:0] wr_addr,
    input  logic [`XLEN-1:0]           wr_data,
    input  logic [`REG_ADDR_WIDTH-1:0] dbg_raddr,
    output logic [`XLEN-1:0]           rs1_data,
    output logic [`XLEN-1:0]           rs2_data,
    output logic [`XLEN-1:0]           dbg_rdata
);

    logic [`XLEN-1:0] regs [`REG_DATA_DEPTH];

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            for (int i = 0; i < `REG_DATA_DEPTH; i++) begin
                regs[i] <= '0;
            end
        end else if (wr_en && (wr_addr != '0)) begin  // x0 is read only
            regs[wr_addr] <= wr_data;
        end
    end

    // all three read ports are combinational
    assign rs1_data  = regs[rs1_addr];
    assign rs2_data  = regs[rs2_addr];
    assign dbg_rdata = regs[dbg_raddr];

endmodule

// ==== hw/rv_writeback.sv ====
`timescale 1ns/1ps
`include "rv_core_cfg.svh"

module rv_writeback (
    input  logic                       clk,
    input  logic                       rst_n,
    input  logic                       ex_valid,
    input  logic [`XLEN-1:0]           ex_result,
    input  logic [`REG_ADDR_WIDTH-1:0] ex_rd,
    input  logic                       ex_wen,
    input  rv_pkg::ext_mode_e          ext_mode,
    output logic                       wr_en,
    output logic [`REG_ADDR_WIDTH-1:0] wr_addr,
    output logic [`XLEN-1:0]           wr_data,
    output logic                       wb_done
);

    logic [`XLEN-1:0] ext_data;

    always_comb begin
        case (ext_mode)
            rv_pkg::SEXT32: ext_data = {{(`XLEN-32){ex_result[31]}}, ex_result[31:0]};  // addw, subw, addiw
            default:        ext_data = ex_result;
        endcase
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            wr_en   <= 1'b0;
            wb_done <= 1'b0;
        end else begin
            wr_en   <= ex_valid && ex_wen;  // one strobe per writing instr
            wb_done <= ex_valid;            // every instr retires, write or not
        end
    end

    always_ff @(posedge clk) begin
        if (ex_valid) begin
            wr_addr <= ex_rd;
            wr_data <= ext_data;
        end
    end

endmodule

// ==== hw/rv_execute.sv ====
`timescale 1ns/1ps
`include "rv_core_cfg.svh"

module rv_execute (
    input  logic                       clk,
    input  logic                       rst_n,
    input  logic                       dec_valid,
    input  logic [`XLEN-1:0]           op_a,
    input  logic [`XLEN-1:0]           op_b,
    input  rv_pkg::alu_op_e            alu_op,
    input  logic                       word_op,
    input  logic [`REG_ADDR_WIDTH-1:0] rd,
    input  logic                       rd_wen,
    output logic                       ex_valid,
    output logic [`XLEN-1:0]           ex_result,
    output logic [`REG_ADDR_WIDTH-1:0] ex_rd,
    output logic                       ex_wen,
    output rv_pkg::ext_mode_e          ext_mode
);

    logic [5:0]       shamt;
    logic [`XLEN-1:0] srl_src;
    logic [`XLEN-1:0] alu_res;

    assign shamt   = word_op ? {1'b0, op_b[4:0]} : op_b[5:0];
    assign srl_src = word_op ? {{(`XLEN-32){1'b0}}, op_a[31:0]} : op_a;  // word shift sees low half

    always_comb begin
        case (alu_op)
            rv_pkg::ADD:    alu_res = op_a + op_b;
            rv_pkg::SUB:    alu_res = op_a - op_b;
            rv_pkg::AND:    alu_res = op_a & op_b;
            rv_pkg::OR:     alu_res = op_a | op_b;
            rv_pkg::XOR:    alu_res = op_a ^ op_b;
            rv_pkg::SLL:    alu_res = op_a << shamt;
            rv_pkg::SRL:    alu_res = srl_src >> shamt;
            rv_pkg::PASS_B: alu_res = op_b;
            default:        alu_res = '0;
        endcase
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            ex_valid <= 1'b0;
            ex_wen   <= 1'b0;
            ext_mode <= rv_pkg::FULL;
        end else begin
            ex_valid <= dec_valid;
            if (dec_valid) begin
                ex_wen   <= rd_wen;
                ext_mode <= word_op ? rv_pkg::SEXT32 : rv_pkg::FULL;
            end
        end
    end

    // result and destination ride along without reset
    always_ff @(posedge clk) begin
        if (dec_valid) begin
            ex_result <= alu_res;
            ex_rd     <= rd;
        end
    end

endmodule

// ==== hw/rv_decode.sv ====
`timescale 1ns/1ps
`include "rv_core_cfg.svh"

module rv_decode (
    input  logic                       clk,
    input  logic                       rst_n,
    input  logic                       accept,
    input  logic [31:0]                instr,
    input  logic [`XLEN-1:0]           rs1_data,
    input  logic [`XLEN-1:0]           rs2_data,
    output logic [`REG_ADDR_WIDTH-1:0] rs1_addr,
    output logic [`REG_ADDR_WIDTH-1:0] rs2_addr,
    output logic                       dec_valid,
    output logic [`XLEN-1:0]           op_a,
    output logic [`XLEN-1:0]           op_b,
    output rv_pkg::alu_op_e            alu_op,
    output logic                       word_op,
    output logic [`REG_ADDR_WIDTH-1:0] rd,
    output logic                       rd_wen
);

    rv_pkg::instr_u  iw;
    rv_pkg::alu_op_e nxt_op;
    logic            nxt_word;
    logic            nxt_wen;
    logic            use_imm;
    logic [`XLEN-1:0] imm;

    assign iw       = instr;
    assign rs1_addr = iw.r.rs1;  // register file reads are combinational
    assign rs2_addr = iw.r.rs2;

    always_comb begin
        nxt_op   = rv_pkg::ADD;
        nxt_word = 1'b0;
        nxt_wen  = 1'b0;
        use_imm  = 1'b0;
        imm      = {{(`XLEN-12){iw.i.imm12[11]}}, iw.i.imm12};  // i-type sign extension
        case (iw.r.opcode)
            rv_pkg::OP: begin
                nxt_wen = 1'b1;
                case (iw.r.funct3)
                    3'b000: nxt_op = iw.r.funct7[5] ? rv_pkg::SUB : rv_pkg::ADD;
                    3'b001: nxt_op = rv_pkg::SLL;
                    3'b100: nxt_op = rv_pkg::XOR;
                    3'b101: begin
                        nxt_op  = rv_pkg::SRL;
                        nxt_wen = !iw.r.funct7[5];  // sra not supported
                    end
                    3'b110: nxt_op = rv_pkg::OR;
                    3'b111: nxt_op = rv_pkg::AND;
                    default: nxt_wen = 1'b0;  // slt, sltu
                endcase
            end
            rv_pkg::OP_IMM: begin
                use_imm = 1'b1;
                nxt_wen = (iw.i.funct3 == 3'b000);  // addi only
            end
            rv_pkg::OP_32: begin
                nxt_word = 1'b1;
                nxt_op   = iw.r.funct7[5] ? rv_pkg::SUB : rv_pkg::ADD;
                nxt_wen  = (iw.r.funct3 == 3'b000) && (iw.r.funct7[4:0] == 5'd0)
                           && (iw.r.funct7[6] == 1'b0);
            end
            rv_pkg::OP_IMM_32: begin
                nxt_word = 1'b1;
                use_imm  = 1'b1;
                nxt_wen  = (iw.i.funct3 == 3'b000);  // addiw only
            end
            rv_pkg::LUI: begin
                nxt_op  = rv_pkg::PASS_B;
                use_imm = 1'b1;
                nxt_wen = 1'b1;
                imm     = {{(`XLEN-32){iw.u.imm20[19]}}, iw.u.imm20, 12'h000};
            end
            default: nxt_wen = 1'b0;  // retired without a write
        endcase
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            dec_valid <= 1'b0;
            rd_wen    <= 1'b0;
            word_op   <= 1'b0;
            alu_op    <= rv_pkg::ADD;
        end else begin
            dec_valid <= accept;
            if (accept) begin
                rd_wen  <= nxt_wen;
                word_op <= nxt_word;
                alu_op  <= nxt_op;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            op_a <= rs1_data;
            op_b <= use_imm ? imm : rs2_data;
            rd   <= iw.r.rd;  // rd sits at the same bits in every layout
        end
    end

endmodule

// ==== hw/rv_pkg.sv ====
package rv_pkg;

    typedef enum logic [3:0] {
        ADD    = 4'd0,
        SUB    = 4'd1,
        AND    = 4'd2,
        OR     = 4'd3,
        XOR    = 4'd4,
        SLL    = 4'd5,
        SRL    = 4'd6,
        PASS_B = 4'd7   // lui result is the prepared operand b
    } alu_op_e;

    typedef enum logic {
        FULL   = 1'b0,  // keep all 64 bits
        SEXT32 = 1'b1   // word result, copy bit 31 upward
    } ext_mode_e;

    typedef struct packed {
        logic [6:0] funct7;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [4:0] rd;
        logic [6:0] opcode;
    } r_fmt_t;

    typedef struct packed {
        logic [11:0] imm12;
        logic [4:0]  rs1;
        logic [2:0]  funct3;
        logic [4:0]  rd;
        logic [6:0]  opcode;
    } i_fmt_t;

    typedef struct packed {
        logic [19:0] imm20;
        logic [4:0]  rd;
        logic [6:0]  opcode;
    } u_fmt_t;

    // one instruction word, three field layouts
    typedef union packed {
        r_fmt_t      r;
        i_fmt_t      i;
        u_fmt_t      u;
        logic [31:0] raw;
    } instr_u;

    localparam logic [6:0] OP        = 7'b0110011;
    localparam logic [6:0] OP_IMM    = 7'b0010011;
    localparam logic [6:0] OP_32     = 7'b0111011;
    localparam logic [6:0] OP_IMM_32 = 7'b0011011;
    localparam logic [6:0] LUI       = 7'b0110111;

endpackage

// ==== hw/rv_core_cfg.svh ====
`ifndef RV_CORE_CFG_SVH
`define RV_CORE_CFG_SVH

// core geometry shared by every stage

`define XLEN           64  // register data width
`define REG_ADDR_WIDTH 5   // register index width
`define REG_DATA_DEPTH 32  // number of integer registers

`endif
